//--- common/led_matrix_pkg.sv
/*
 * shared geometry and types for one 64x32 hub75 panel with 1:16 scan
 * only this panel size is supported; widths follow from the localparams
 */
package led_matrix_pkg;

    // panel geometry
    localparam int PIXEL_WIDTH     = 64;
    localparam int SUBPANEL_ROWS   = 16;
    localparam int PANEL_HALVES    = 2;
    localparam int BRIGHTNESS_BITS = 8;

    // output enable timing, in clk_in cycles
    localparam int OE_UNIT_CYCLES  = 1;
    localparam int OVERLAP_CYCLES  = PIXEL_WIDTH + 4;
    localparam int OE_COUNT_WIDTH  = $clog2((1 << BRIGHTNESS_BITS) * OE_UNIT_CYCLES);

    // one half panel of pixels
    localparam int BUFFER_DEPTH    = SUBPANEL_ROWS * PIXEL_WIDTH;

    typedef logic [$clog2(PIXEL_WIDTH)-1:0]                   col_addr_t;
    typedef logic [$clog2(PIXEL_WIDTH):0]                     col_addr_count_t;
    typedef logic [$clog2(SUBPANEL_ROWS)-1:0]                 row_subpanel_addr_t;
    // msb picks the upper or lower half
    typedef logic [$clog2(SUBPANEL_ROWS * PANEL_HALVES)-1:0]  panel_row_t;
    typedef logic [$clog2(BUFFER_DEPTH)-1:0]                  buffer_addr_t;
    typedef logic [BRIGHTNESS_BITS-1:0]                       brightness_level_t;
    typedef logic [OE_COUNT_WIDTH-1:0]                        oe_count_t;

    // scan starts on the brightest plane
    localparam brightness_level_t MSB_PLANE = brightness_level_t'(1 << (BRIGHTNESS_BITS - 1));

    typedef struct packed {
        logic [BRIGHTNESS_BITS-1:0] r;
        logic [BRIGHTNESS_BITS-1:0] g;
        logic [BRIGHTNESS_BITS-1:0] b;
    } rgb_pixel_t;

    typedef struct packed {
        panel_row_t row;
        col_addr_t  column;
        rgb_pixel_t pixel;
    } pixel_write_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_bits_t;

    typedef struct packed {
        rgb_bits_t          rgb0;
        rgb_bits_t          rgb1;
        row_subpanel_addr_t row_address;
        logic               clk_pixel;
        logic               row_latch;
        logic               output_enable;
    } hub75_pins_t;

endpackage

//--- matrix_scan/countdown_timer.sv
/*
 * loadable down-counter, stops at zero
 * start must not arrive while the counter is still running
 */
`timescale 1ns/1ps

module countdown_timer #(
    parameter int COUNTER_WIDTH = 7
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // running is combinational so it drops in the cycle the count hits zero
    assign running = (counter != '0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (running) begin
            counter <= counter - 1'b1;
        end
    end

    // a reload mid-count would cut the line short
    start_while_idle: assert property (
        @(posedge clk_in) disable iff (reset)
        start |-> !running
    );

endmodule

//--- matrix_scan/brightness_timeout.sv
/*
 * output enable pulse for the active bit plane, weight x OE_UNIT_CYCLES long
 * a row latch reloads the count even if the previous pulse is still running
 */
`timescale 1ns/1ps

module brightness_timeout (
    input  logic                              clk_in,
    input  logic                              reset,
    input  logic                              row_latch,
    input  led_matrix_pkg::brightness_level_t brightness_mask_active,
    output logic                              output_enable,
    output logic                              exceeded_overlap_time
);

    import led_matrix_pkg::*;

    oe_count_t remaining;
    oe_count_t plane_cycles;

    // one-hot mask doubles as the plane weight
    assign plane_cycles = oe_count_t'(brightness_mask_active * OE_UNIT_CYCLES);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            remaining <= '0;
        end else if (row_latch) begin
            remaining <= plane_cycles;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // leds on while cycles are left
    assign output_enable = (remaining != '0);

    // tail of the pulse, the next line may start shifting
    assign exceeded_overlap_time = (remaining <= oe_count_t'(OVERLAP_CYCLES));

    // more than one bit would give a weight that is not a plane
    mask_onehot: assert property (
        @(posedge clk_in) disable iff (reset)
        $onehot0(brightness_mask_active)
    );

endmodule

//--- matrix_scan/matrix_scan.sv
/*
 * hub75 scan sequencer: 64 column loads per line, then a one-cycle row latch
 * clk_pixel is clk_in gated, so it must only drive panel pins, never logic
 */
`timescale 1ns/1ps

module matrix_scan (
    input  logic                               reset,
    input  logic                               clk_in,
    output led_matrix_pkg::col_addr_t          column_address,
    output led_matrix_pkg::row_subpanel_addr_t row_address,
    output led_matrix_pkg::row_subpanel_addr_t row_address_active,
    output logic                               clk_pixel_load_en,
    output logic                               clk_pixel,
    output logic                               row_latch,
    output logic                               output_enable,
    output led_matrix_pkg::brightness_level_t  brightness_mask
);

    import led_matrix_pkg::*;

    typedef logic [1:0] scan_state_t;

    scan_state_t       state;
    scan_state_t       row_latch_state;
    logic              state_advance;
    logic              advance_pulse;
    logic              scan_idle;
    logic              start_timers;
    logic              exceeded_overlap_time;
    logic              load_en_d;
    logic              clk_pixel_en;
    logic              latch_rise;
    brightness_level_t brightness_mask_active;

    // previous oe is off, or far enough into its tail
    assign state_advance = !output_enable || exceeded_overlap_time;

    // nothing of the last line still in flight
    assign scan_idle = (state == 2'b00) && !clk_pixel_load_en && !load_en_d &&
                       (row_latch_state == 2'b00);
    assign advance_pulse = state_advance && scan_idle;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00;
        end else begin
            state <= {state[0], advance_pulse};
        end
    end

    // second rising edge after the advance loads both timers
    assign start_timers = (state == 2'b01);

    // 64 load cycles per line
    countdown_timer #(
        .COUNTER_WIDTH($bits(col_addr_count_t))
    ) i_load_timer (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (start_timers),
        .value  (col_addr_count_t'(PIXEL_WIDTH)),
        .counter(),
        .running(clk_pixel_load_en)
    );

    // column address, 63 down to 0 then holds
    countdown_timer #(
        .COUNTER_WIDTH($bits(col_addr_t))
    ) i_column_timer (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (start_timers),
        .value  (col_addr_t'(PIXEL_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    // buffer output lags the load gate by a cycle
    always_ff @(posedge clk_in) begin
        if (reset) begin
            load_en_d <= 1'b0;
        end else begin
            load_en_d <= clk_pixel_load_en;
        end
    end

    // row_latch_state goes to 2'b10 on this falling edge
    assign latch_rise = row_latch_state[0] && !load_en_d;

    // falling edge side: pixel clock gate, latch, plane and row stepping
    always_ff @(negedge clk_in) begin
        if (reset) begin
            clk_pixel_en           <= 1'b0;
            row_latch_state        <= 2'b00;
            brightness_mask        <= MSB_PLANE;
            brightness_mask_active <= '0;
            row_address            <= '0;
            row_address_active     <= '0;
        end else begin
            clk_pixel_en    <= load_en_d;
            row_latch_state <= {row_latch_state[0], load_en_d};
            if (latch_rise) begin
                // hand the loaded line to the leds
                brightness_mask_active <= brightness_mask;
                row_address_active     <= row_address;
                if (brightness_mask <= brightness_level_t'(1)) begin
                    // last plane done, move on to the next row
                    brightness_mask <= MSB_PLANE;
                    row_address     <= row_address + 1'b1;
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    // gate changes on the falling edge, so no runt pulses
    assign clk_pixel = clk_in && clk_pixel_en;
    assign row_latch = (row_latch_state == 2'b10);

    brightness_timeout i_brightness_timeout (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask_active),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap_time)
    );

    // latch is a single cycle
    latch_one_cycle: assert property (
        @(negedge clk_in) disable iff (reset)
        row_latch |=> !row_latch
    );

endmodule

//--- source/pixel_half_buffer.sv
/*
 * pixel memory of one half panel, 16 rows x 64 columns of 8-bit rgb
 * async read into a register, so it maps to distributed ram
 */
`timescale 1ns/1ps

module pixel_half_buffer #(
    parameter int HALF = 0
) (
    input  logic                               clk_in,
    input  logic                               reset,
    input  led_matrix_pkg::pixel_write_t       pixel_write,
    input  logic                               pixel_write_valid,
    input  led_matrix_pkg::row_subpanel_addr_t row_address,
    input  led_matrix_pkg::col_addr_t          column_address,
    input  led_matrix_pkg::brightness_level_t  brightness_mask,
    input  logic                               clk_pixel_load_en,
    output led_matrix_pkg::rgb_bits_t          rgb_bits
);

    import led_matrix_pkg::*;

    rgb_pixel_t   frame [BUFFER_DEPTH];
    buffer_addr_t write_addr;
    buffer_addr_t read_addr;
    rgb_pixel_t   read_pixel;
    logic         write_hit;

    // row msb selects the half, the rest is the row inside it
    assign write_hit  = pixel_write_valid &&
                        (pixel_write.row[$bits(panel_row_t)-1] == 1'(HALF));
    assign write_addr = {row_subpanel_addr_t'(pixel_write.row), pixel_write.column};

    always_ff @(posedge clk_in) begin
        if (write_hit) begin
            frame[write_addr] <= pixel_write.pixel;
        end
    end

    assign read_addr  = {row_address, column_address};
    assign read_pixel = frame[read_addr];

    // one bit plane per channel, picked by the one-hot mask
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_bits <= '0;
        end else if (clk_pixel_load_en) begin
            rgb_bits.r <= |(read_pixel.r & brightness_mask);
            rgb_bits.g <= |(read_pixel.g & brightness_mask);
            rgb_bits.b <= |(read_pixel.b & brightness_mask);
        end
    end

endmodule

//--- source/hub75_output.sv
/*
 * panel pin stage; colour bits move on the falling edge for the rising clk_pixel
 * clock, latch and oe pass straight through with the scan timing
 */
`timescale 1ns/1ps

module hub75_output (
    input  logic                                                   clk_in,
    input  logic                                                   reset,
    input  led_matrix_pkg::rgb_bits_t [led_matrix_pkg::PANEL_HALVES-1:0] rgb_half,
    input  logic                                                   clk_pixel,
    input  logic                                                   row_latch,
    input  logic                                                   output_enable,
    input  led_matrix_pkg::row_subpanel_addr_t                     row_address_active,
    output led_matrix_pkg::hub75_pins_t                            hub75
);

    import led_matrix_pkg::*;

    rgb_bits_t [PANEL_HALVES-1:0] rgb_q;

    // half a cycle of setup before the panel clock rises
    always_ff @(negedge clk_in) begin
        if (reset) begin
            rgb_q <= '0;
        end else begin
            rgb_q <= rgb_half;
        end
    end

    // upper half on rgb0, lower on rgb1
    assign hub75.rgb0          = rgb_q[0];
    assign hub75.rgb1          = rgb_q[1];
    assign hub75.row_address   = row_address_active;
    assign hub75.clk_pixel     = clk_pixel;
    assign hub75.row_latch     = row_latch;
    assign hub75.output_enable = output_enable;

endmodule

//--- source/led_matrix_top.sv
/*
 * 64x32 hub75 driver, binary code modulation over 8 planes
 * host writes are never refused; no read-back, no double buffering
 */
`timescale 1ns/1ps

module led_matrix_top (
    input  logic                               clk_in,
    input  logic                               reset,
    input  led_matrix_pkg::pixel_write_t       pixel_write,
    input  logic                               pixel_write_valid,
    output led_matrix_pkg::hub75_pins_t        hub75,
    output led_matrix_pkg::row_subpanel_addr_t row_address_active
);

    import led_matrix_pkg::*;

    col_addr_t                    column_address;
    row_subpanel_addr_t           row_address;
    brightness_level_t            brightness_mask;
    logic                         clk_pixel_load_en;
    logic                         clk_pixel;
    logic                         row_latch;
    logic                         output_enable;
    rgb_bits_t [PANEL_HALVES-1:0] rgb_half;

    matrix_scan i_matrix_scan (
        .reset             (reset),
        .clk_in            (clk_in),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .clk_pixel_load_en (clk_pixel_load_en),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .brightness_mask   (brightness_mask)
    );

    // same scan address into both halves
    for (genvar i = 0; i < PANEL_HALVES; i++) begin : g_half
        pixel_half_buffer #(
            .HALF(i)
        ) i_half_buffer (
            .clk_in           (clk_in),
            .reset            (reset),
            .pixel_write      (pixel_write),
            .pixel_write_valid(pixel_write_valid),
            .row_address      (row_address),
            .column_address   (column_address),
            .brightness_mask  (brightness_mask),
            .clk_pixel_load_en(clk_pixel_load_en),
            .rgb_bits         (rgb_half[i])
        );
    end

    hub75_output i_hub75_output (
        .clk_in            (clk_in),
        .reset             (reset),
        .rgb_half          (rgb_half),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .row_address_active(row_address_active),
        .hub75             (hub75)
    );

endmodule

//--- dv/tb_led_matrix.sv
/*
 * directed testbench for led_matrix_top; a frame model predicts every shifted line
 * the plane mask is read from the scan block by hierarchy at each row latch
 */
`timescale 1ns/1ps

module tb_led_matrix;

    import led_matrix_pkg::*;

    // worst case line: full msb pulse plus shift and latch
    localparam int FRAME_LINES    = SUBPANEL_ROWS * BRIGHTNESS_BITS;
    localparam int LINE_BOUND     = 256 * OE_UNIT_CYCLES + PIXEL_WIDTH + 16;
    localparam int TIMEOUT_CYCLES = 6 * FRAME_LINES * LINE_BOUND + 4 * BUFFER_DEPTH;

    logic               clk_in;
    logic               reset;
    pixel_write_t       pixel_write;
    logic               pixel_write_valid;
    hub75_pins_t        hub75;
    row_subpanel_addr_t row_address_active;
    logic               clk_pixel;

    rgb_pixel_t         model [SUBPANEL_ROWS * PANEL_HALVES][PIXEL_WIDTH];
    integer             seed = 42;
    int                 value_errors = 0;
    int                 other_errors = 0;
    bit                 data_check = 0;
    int                 latch_count = 0;
    int                 pixel_total = 0;
    int                 pixel_mark = 0;
    int                 oe_seen = 0;
    int                 oe_count = 0;
    bit                 oe_active = 0;
    rgb_bits_t          line0 [PIXEL_WIDTH];
    rgb_bits_t          line1 [PIXEL_WIDTH];
    brightness_level_t  exp_mask;
    brightness_level_t  latch_mask;
    brightness_level_t  oe_mask;
    row_subpanel_addr_t exp_row;
    row_subpanel_addr_t latch_row;

    led_matrix_top i_dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .pixel_write       (pixel_write),
        .pixel_write_valid (pixel_write_valid),
        .hub75             (hub75),
        .row_address_active(row_address_active)
    );

    assign clk_pixel = hub75.clk_pixel;

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    task automatic check_bits(string name, rgb_bits_t got, rgb_bits_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_row(string name, row_subpanel_addr_t got, row_subpanel_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_mask(string name, brightness_level_t got, brightness_level_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_oe_len(string name, int got, int exp);
        if (got != exp) begin
            value_errors++;
            $display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_edges(string name, int got, int exp);
        if (got != exp) begin
            value_errors++;
            $display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_pin(string name, logic got, logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    // a channel bit is lit when its value has the plane bit set
    function automatic rgb_bits_t plane_bits(rgb_pixel_t p, brightness_level_t m);
        rgb_bits_t bits;
        bits.r = (p.r & m) != '0;
        bits.g = (p.g & m) != '0;
        bits.b = (p.b & m) != '0;
        return bits;
    endfunction

    // k-th pixel clock of the line carries column 63-k
    task automatic check_line(row_subpanel_addr_t row, brightness_level_t mask);
        int col;
        for (int k = 0; k < PIXEL_WIDTH; k++) begin
            col = PIXEL_WIDTH - 1 - k;
            check_bits($sformatf("rgb0 row %0d col %0d", row, col), line0[k],
                       plane_bits(model[int'(row)][col], mask));
            check_bits($sformatf("rgb1 row %0d col %0d", row, col), line1[k],
                       plane_bits(model[int'(row) + SUBPANEL_ROWS][col], mask));
        end
    endtask

    // line capture on the panel clock
    always @(posedge clk_pixel) begin : pixel_monitor
        int k;
        k = pixel_total - pixel_mark;
        if (k >= 0 && k < PIXEL_WIDTH) begin
            line0[k] = hub75.rgb0;
            line1[k] = hub75.rgb1;
        end
        pixel_total++;
    end

    // row latch: plane order, row stepping, edge count, line data
    always @(posedge clk_in) begin : latch_monitor
        brightness_level_t mask;
        row_subpanel_addr_t row;
        if (reset) begin
            exp_mask    = MSB_PLANE;
            exp_row     = '0;
            pixel_mark  = pixel_total;
            latch_count = 0;
        end else if (hub75.row_latch) begin
            mask = i_dut.i_matrix_scan.brightness_mask_active;
            row  = hub75.row_address;
            check_edges("clk_pixel rising edges", pixel_total - pixel_mark, PIXEL_WIDTH);
            pixel_mark = pixel_total;
            check_mask("brightness_mask_active", mask, exp_mask);
            check_row("hub75.row_address", row, exp_row);
            check_row("row_address_active", row_address_active, exp_row);
            if (data_check) begin
                check_line(exp_row, exp_mask);
            end
            latch_mask = exp_mask;
            latch_row  = exp_row;
            // lsb plane ends the row
            if (exp_mask == brightness_level_t'(1)) begin
                exp_mask = MSB_PLANE;
                exp_row  = exp_row + 1'b1;
            end else begin
                exp_mask = exp_mask >> 1;
            end
            latch_count++;
        end
    end

    task automatic close_oe_pulse();
        check_oe_len($sformatf("output_enable length, mask 0x%h", oe_mask), oe_count,
                     int'(oe_mask) * OE_UNIT_CYCLES);
        oe_active = 0;
    endtask

    // oe counted on the falling edge, a new latch closes the old pulse
    always @(negedge clk_in) begin : oe_monitor
        if (reset) begin
            oe_active = 0;
            oe_seen   = 0;
        end else begin
            if (latch_count != oe_seen) begin
                if (oe_active) begin
                    close_oe_pulse();
                end
                oe_active = 1;
                oe_mask   = latch_mask;
                oe_count  = 0;
                oe_seen   = latch_count;
            end
            if (oe_active) begin
                if (hub75.output_enable) begin
                    oe_count++;
                end else begin
                    close_oe_pulse();
                end
            end
        end
    end

    // returns on the falling edge right after the n-th latch
    task automatic wait_latches(int n);
        int target;
        target = latch_count + n;
        while (latch_count < target) begin
            @(negedge clk_in);
        end
    endtask

    task automatic write_pixel(int row, int col, rgb_pixel_t p);
        @(negedge clk_in);
        pixel_write.row    = panel_row_t'(row);
        pixel_write.column = col_addr_t'(col);
        pixel_write.pixel  = p;
        pixel_write_valid  = 1'b1;
        model[row][col]    = p;
    endtask

    task automatic end_writes();
        @(negedge clk_in);
        pixel_write_valid = 1'b0;
        // the line in flight may mix old and new data
        wait_latches(1);
        data_check = 1;
    endtask

    task automatic test_reset_idle();
        @(negedge clk_in);
        check_pin("hub75.row_latch", hub75.row_latch, 1'b0);
        check_pin("hub75.output_enable", hub75.output_enable, 1'b0);
        check_row("row_address_active", row_address_active, '0);
    endtask

    task automatic test_plane_order();
        int n;
        wait_latches(FRAME_LINES + BRIGHTNESS_BITS);
        // latch n since reset shows row n/8 and plane 7 - n%8
        n = latch_count - 1;
        check_row("row_address_active after wrap", row_address_active,
                  row_subpanel_addr_t'((n / BRIGHTNESS_BITS) % SUBPANEL_ROWS));
        check_mask("brightness_mask_active after wrap",
                   i_dut.i_matrix_scan.brightness_mask_active,
                   brightness_level_t'(MSB_PLANE >> (n % BRIGHTNESS_BITS)));
    endtask

    task automatic test_frame_data();
        data_check = 0;
        for (int r = 0; r < SUBPANEL_ROWS * PANEL_HALVES; r++) begin
            for (int c = 0; c < PIXEL_WIDTH; c++) begin
                write_pixel(r, c, rgb_pixel_t'($random(seed)));
            end
        end
        end_writes();
        // every line of a full frame is compared at its latch
        wait_latches(FRAME_LINES + 1);
    endtask

    task automatic test_oe_length();
        wait_latches(2 * BRIGHTNESS_BITS);
    endtask

    task automatic test_half_routing();
        int r;
        bit found;
        r = (int'(row_address_active) + 3) % SUBPANEL_ROWS;
        found = 0;
        data_check = 0;
        // same scan row in both halves, distinct columns and colours
        write_pixel(r, 5, 24'hff00ff);
        write_pixel(r + SUBPANEL_ROWS, 9, 24'h00ff00);
        end_writes();
        for (int i = 0; i < 2 * FRAME_LINES && !found; i++) begin
            wait_latches(1);
            found = (latch_row == row_subpanel_addr_t'(r)) &&
                    (latch_mask == brightness_level_t'(1));
        end
        if (!found) begin
            other_errors++;
            $display("half routing test never reached the lsb plane of the written row");
        end else begin
            // lsb plane: magenta on the upper half, green on the lower
            check_bits("rgb0 written pixel", line0[PIXEL_WIDTH - 1 - 5], 3'b101);
            check_bits("rgb1 written pixel", line1[PIXEL_WIDTH - 1 - 9], 3'b010);
        end
    endtask

    task automatic test_pixel_edges();
        wait_latches(4);
    endtask

    initial begin
        reset             = 1'b1;
        pixel_write       = '0;
        pixel_write_valid = 1'b0;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;

        test_reset_idle();
        test_plane_order();
        test_frame_data();
        test_oe_length();
        test_half_routing();
        test_pixel_edges();

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // bounded by a few frames of worst case lines plus the frame writes
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_in);
        $display("watchdog expired after %0d cycles before the tests finished", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- compile.f
common/led_matrix_pkg.sv
matrix_scan/countdown_timer.sv
matrix_scan/brightness_timeout.sv
matrix_scan/matrix_scan.sv
source/pixel_half_buffer.sv
source/hub75_output.sv
source/led_matrix_top.sv
dv/tb_led_matrix.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the led matrix testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_led_matrix \
    -f compile.f \
    --Mdir obj_dir \
    -o tb_led_matrix
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_led_matrix > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
